// File: sim.f
hw/afu_mmio_pkg.sv
hw/afu_mem_pkg.sv
hw/line_fifo.sv
hw/local_mem_master.sv
hw/mem_to_host_copy.sv
hw/host_to_mem_copy.sv
hw/cmd_fsm.sv
hw/mmio_regs.sv
hw/afu_top.sv
bench/afu_checker.sv
bench/afu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module afu_tb -f sim.f -o afu_sim; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/afu_sim)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "All checks passed" <<< "$output"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: bench/afu_tb.sv
module afu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import afu_mmio_pkg::*;
  import afu_mem_pkg::*;

  localparam int NUM_COPIES = 8;

  logic       clk;
  logic       reset;
  logic       mmio_wr_valid;
  logic       mmio_rd_valid;
  mmio_addr_t mmio_addr;
  mmio_tid_t  mmio_tid;
  mmio_data_t mmio_wdata;
  logic       mmio_rsp_valid;
  mmio_tid_t  mmio_rsp_tid;
  mmio_data_t mmio_rsp_data;
  logic       host_rd_req_valid;
  host_addr_t host_rd_req_addr;
  rd_tag_t    host_rd_req_tag;
  logic       host_rd_rsp_valid = 1'b0;
  rd_tag_t    host_rd_rsp_tag = '0;
  line_t      host_rd_rsp_data = '0;
  logic       host_rd_almost_full = 1'b0;
  logic       host_wr_req_valid;
  host_addr_t host_wr_req_addr;
  line_t      host_wr_req_data;
  logic       host_wr_rsp_valid = 1'b0;
  logic       host_wr_almost_full = 1'b0;
  mem_addr_t  avs_address;
  line_t      avs_writedata;
  line_t      avs_readdata = '0;
  logic       avs_waitrequest = 1'b0;
  logic       avs_read;
  logic       avs_write;
  logic       avs_readdatavalid = 1'b0;

  // Memory models that read back a fill pattern for lines never written
  line_t      host_mem [host_addr_t];
  line_t      local_mem [mem_addr_t];
  host_addr_t rd_addr_q [$];     // Host reads not yet answered
  rd_tag_t    rd_tag_q [$];
  line_t      avs_rd_q [$];      // Avalon read data in flight in issue order
  int         acks_owed = 0;
  int         host_rd_count = 0;
  int         host_wr_count = 0;
  int         avs_rd_count = 0;
  int         avs_wr_count = 0;

  logic        next_rd_rsp_valid = 1'b0;
  rd_tag_t     next_rd_rsp_tag = '0;
  line_t       next_rd_rsp_data = '0;
  logic        next_wr_rsp_valid = 1'b0;
  logic        next_readdatavalid = 1'b0;
  line_t       next_readdata = '0;
  logic        next_rd_almost_full = 1'b0;
  logic        next_wr_almost_full = 1'b0;
  logic        next_waitrequest = 1'b0;
  int          seed;
  int unsigned cycles = 0;
  int unsigned limit = 0;
  mem_addr_t   last_mem = '0;
  int          sizes [NUM_COPIES];
  logic        dirs [NUM_COPIES];

  afu_top u_dut (.*);

  bind afu_top afu_checker u_checker (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic line_t fill_line(input logic [63:0] addr, input logic [7:0] space);
    line_t l;
    for (int i = 0; i < 8; i++) begin
      l[i*64 +: 64] = {space, 14'(i), addr[41:0]};
    end
    return l;
  endfunction

  function automatic line_t host_line(input host_addr_t addr);
    return host_mem.exists(addr) ? host_mem[addr] : fill_line(64'(addr), 8'h4f);
  endfunction

  function automatic line_t local_line(input mem_addr_t addr);
    return local_mem.exists(addr) ? local_mem[addr] : fill_line(64'(addr), 8'h1c);
  endfunction

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check(input logic [511:0] got, input logic [511:0] exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0d ns: %s got %0h expected %0h", $time, what, got, exp);
      abort_run();
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout: the test did not finish within %0d cycles", limit);
      abort_run();
    end
  end

  // Sample DUT requests at the falling edge and plan the next inputs
  always @(negedge clk) begin
    int pick;
    if (!reset) begin
      if (host_rd_req_valid) begin
        rd_addr_q.push_back(host_rd_req_addr);
        rd_tag_q.push_back(host_rd_req_tag);
        host_rd_count++;
      end
      if (host_wr_req_valid) begin
        host_mem[host_wr_req_addr] = host_wr_req_data;
        host_wr_count++;
        acks_owed++;
      end
      if (avs_write && !avs_waitrequest) begin
        local_mem[avs_address] = avs_writedata;
        avs_wr_count++;
      end
      if (avs_read && !avs_waitrequest) begin
        avs_rd_q.push_back(local_line(avs_address));
        avs_rd_count++;
      end
      next_rd_rsp_valid = 1'b0;
      if (rd_addr_q.size() != 0 && ($random(seed) & 1) != 0) begin
        pick = int'($unsigned($random(seed)) % rd_addr_q.size());   // Any open tag of the batch
        next_rd_rsp_valid = 1'b1;
        next_rd_rsp_tag   = rd_tag_q[pick];
        next_rd_rsp_data  = host_line(rd_addr_q[pick]);
        rd_addr_q.delete(pick);
        rd_tag_q.delete(pick);
      end
      next_wr_rsp_valid = (acks_owed != 0) && (($random(seed) & 1) != 0);
      if (next_wr_rsp_valid) acks_owed--;
      next_readdatavalid = (avs_rd_q.size() != 0) && (($random(seed) & 1) != 0);
      if (next_readdatavalid) next_readdata = avs_rd_q.pop_front();
      next_rd_almost_full = ($random(seed) & 3) == 0;
      next_wr_almost_full = ($random(seed) & 3) == 0;
      next_waitrequest    = ($random(seed) & 3) == 0;
    end
  end

  always @(posedge clk) begin
    #10;
    host_rd_rsp_valid   = next_rd_rsp_valid;
    host_rd_rsp_tag     = next_rd_rsp_tag;
    host_rd_rsp_data    = next_rd_rsp_data;
    host_wr_rsp_valid   = next_wr_rsp_valid;
    avs_readdatavalid   = next_readdatavalid;
    avs_readdata        = next_readdata;
    host_rd_almost_full = next_rd_almost_full;
    host_wr_almost_full = next_wr_almost_full;
    avs_waitrequest     = next_waitrequest;
  end

  // MMIO tasks start and end 10 ns after a rising edge
  task automatic mmio_write(input mmio_addr_t addr, input mmio_data_t data);
    mmio_wr_valid = 1'b1;
    mmio_addr     = addr;
    mmio_wdata    = data;
    @(posedge clk);
    #10;
    mmio_wr_valid = 1'b0;
  endtask

  task automatic mmio_read(input mmio_addr_t addr, output mmio_data_t data);
    mmio_tid_t tid;
    tid = mmio_tid_t'($random(seed));
    mmio_rd_valid = 1'b1;
    mmio_addr     = addr;
    mmio_tid      = tid;
    @(posedge clk);
    #10;
    mmio_rd_valid = 1'b0;
    @(negedge clk);
    check(mmio_rsp_valid, 1'b1, "MMIO response valid");
    check(mmio_rsp_tid, tid, "MMIO response tid");
    data = mmio_rsp_data;
    @(posedge clk);
    #10;
  endtask

  task automatic run_copy(input logic is_read, input int size);
    host_addr_t io;
    mem_addr_t  mem;
    state_e     busy_state;
    mmio_data_t rsp;
    line_t      expected [$];
    int         host_rd0;
    int         host_wr0;
    int         avs_rd0;
    int         avs_wr0;
    io  = host_addr_t'({$random(seed), $random(seed)});
    mem = mem_addr_t'($random(seed));
    if (is_read && ($random(seed) & 1) != 0) mem = last_mem;   // Read back an earlier write
    if (!is_read) last_mem = mem;
    busy_state = is_read ? STATE_READ : STATE_WRITE;
    mmio_write(MMIO_IO_ADDR, 64'(io));
    mmio_write(MMIO_MEM_ADDR, 64'(mem));
    mmio_write(MMIO_DATA_SIZE, 64'(size));
    for (int i = 0; i < size; i++) begin
      expected.push_back(is_read ? local_line(mem + mem_addr_t'(i))
                                 : host_line(io + host_addr_t'(i)));
    end
    host_rd0 = host_rd_count;
    host_wr0 = host_wr_count;
    avs_rd0  = avs_rd_count;
    avs_wr0  = avs_wr_count;
    mmio_write(MMIO_CMD_TYPE, 64'(is_read ? CMD_MEM_READ : CMD_MEM_WRITE));
    if (size == 0) begin
      @(posedge clk);
      #10;
      mmio_read(MMIO_STATUS, rsp);
      check(rsp, 64'(STATE_IDLE), "status after empty command");
    end else begin
      mmio_read(MMIO_STATUS, rsp);
      check(rsp, 64'(busy_state), "status at copy start");
      // Opposite command while busy must be dropped
      mmio_write(MMIO_CMD_TYPE, 64'(is_read ? CMD_MEM_WRITE : CMD_MEM_READ));
      do begin
        mmio_read(MMIO_STATUS, rsp);
        if (rsp != 64'(STATE_IDLE)) check(rsp, 64'(busy_state), "status during copy");
      end while (rsp != 64'(STATE_IDLE));
    end
    check(host_rd_count - host_rd0, is_read ? 0 : size, "host read requests");
    check(host_wr_count - host_wr0, is_read ? size : 0, "host write requests");
    check(avs_rd_count - avs_rd0, is_read ? size : 0, "Avalon reads");
    check(avs_wr_count - avs_wr0, is_read ? 0 : size, "Avalon writes");
    for (int i = 0; i < size; i++) begin
      if (is_read) check(host_line(io + host_addr_t'(i)), expected[i], "host line");
      else check(local_line(mem + mem_addr_t'(i)), expected[i], "local memory line");
    end
  endtask

  initial begin
    int         total;
    mmio_data_t rsp;
    seed          = 91;
    reset         = 1'b1;
    mmio_wr_valid = 1'b0;
    mmio_rd_valid = 1'b0;
    mmio_addr     = '0;
    mmio_tid      = '0;
    mmio_wdata    = '0;
    total = 0;
    for (int i = 0; i < NUM_COPIES; i++) begin
      sizes[i] = 1 + int'($unsigned($random(seed)) % 40);
      dirs[i]  = (i % 2) == 1;   // Even copies write and odd copies read
      total += sizes[i];
    end
    limit = 200 * total + 2000;
    repeat (4) @(posedge clk);
    #10;
    reset = 1'b0;

    mmio_read(MMIO_DFH, rsp);
    check(rsp, (64'd1 << 60) | (64'd1 << 40), "DFH word");
    mmio_read(MMIO_ID_L, rsp);
    check(rsp, AFU_ID[63:0], "ID low word");
    mmio_read(MMIO_ID_H, rsp);
    check(rsp, AFU_ID[127:64], "ID high word");
    mmio_read(MMIO_RSVD, rsp);
    check(rsp, 64'd0, "reserved word");
    mmio_read(16'h0100, rsp);
    check(rsp, 64'd0, "unmapped word");
    mmio_read(MMIO_STATUS, rsp);
    check(rsp, 64'(STATE_IDLE), "status after reset");

    for (int i = 0; i < NUM_COPIES; i++) begin
      run_copy(dirs[i], sizes[i]);
      if (i == 2) begin
        run_copy(1'b0, 0);
        run_copy(1'b1, 0);
      end
    end

    $display("All checks passed");
    $finish;
  end

endmodule

// File: bench/afu_checker.sv
module afu_checker (
  input logic clk,
  input logic reset,
  input logic mmio_rd_valid,
  input logic mmio_rsp_valid,
  input logic avs_read,
  input logic avs_write,
  input logic host_rd_req_valid,
  input logic host_rd_almost_full
);
  timeunit 1ns;
  timeprecision 1ps;

  // One response per read strobe, exactly one cycle later
  a_rsp_follows_rd: assert property (@(posedge clk) disable iff (reset)
    mmio_rsp_valid == $past(mmio_rd_valid))
    else $error("mmio_rsp_valid does not follow mmio_rd_valid by one cycle");

  a_avs_one_cmd: assert property (@(posedge clk) disable iff (reset)
    !(avs_read && avs_write))
    else $error("avs_read and avs_write high in the same cycle");

  // Almost-full throttles host reads on the following cycle
  a_rd_throttle: assert property (@(posedge clk) disable iff (reset)
    !($past(host_rd_almost_full) && host_rd_req_valid))
    else $error("host read issued one cycle after host_rd_almost_full");

endmodule

// File: hw/afu_top.sv
module afu_top (
  input  logic                     clk,
  input  logic                     reset,

  input  logic                     mmio_wr_valid,
  input  logic                     mmio_rd_valid,
  input  afu_mmio_pkg::mmio_addr_t mmio_addr,
  input  afu_mmio_pkg::mmio_tid_t  mmio_tid,
  input  afu_mmio_pkg::mmio_data_t mmio_wdata,
  output logic                     mmio_rsp_valid,
  output afu_mmio_pkg::mmio_tid_t  mmio_rsp_tid,
  output afu_mmio_pkg::mmio_data_t mmio_rsp_data,

  output logic                     host_rd_req_valid,
  output afu_mem_pkg::host_addr_t  host_rd_req_addr,
  output afu_mem_pkg::rd_tag_t     host_rd_req_tag,
  input  logic                     host_rd_rsp_valid,
  input  afu_mem_pkg::rd_tag_t     host_rd_rsp_tag,
  input  afu_mem_pkg::line_t       host_rd_rsp_data,
  input  logic                     host_rd_almost_full,

  output logic                     host_wr_req_valid,
  output afu_mem_pkg::host_addr_t  host_wr_req_addr,
  output afu_mem_pkg::line_t       host_wr_req_data,
  input  logic                     host_wr_rsp_valid,
  input  logic                     host_wr_almost_full,

  output afu_mem_pkg::mem_addr_t   avs_address,
  output afu_mem_pkg::line_t       avs_writedata,
  input  afu_mem_pkg::line_t       avs_readdata,
  input  logic                     avs_waitrequest,
  output logic                     avs_read,
  output logic                     avs_write,
  input  logic                     avs_readdatavalid
);
  import afu_mmio_pkg::*;
  import afu_mem_pkg::*;

  // Command registers and FSM
  cmd_e       cmd;
  state_e     state;
  host_addr_t io_addr;
  mem_addr_t  mem_addr;
  mem_addr_t  data_size;
  logic       start_read;
  logic       start_write;
  logic       read_done;
  logic       write_done;

  // Local memory requests from the copy engines
  logic       mem_wr_valid;
  logic       mem_wr_ready;
  mem_addr_t  mem_wr_addr;
  line_t      mem_wr_data;
  logic       mem_rd_valid;
  logic       mem_rd_ready;
  mem_addr_t  mem_rd_addr;
  logic       rd_line_valid;
  logic       rd_line_pop;
  line_t      rd_line_data;

  mmio_regs u_mmio_regs (.*);

  cmd_fsm u_cmd_fsm (.*);

  host_to_mem_copy u_host_to_mem (.*);

  mem_to_host_copy u_mem_to_host (.*);

  local_mem_master u_local_mem (.*);

endmodule

// File: hw/mmio_regs.sv
module mmio_regs (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     mmio_wr_valid,
  input  logic                     mmio_rd_valid,
  input  afu_mmio_pkg::mmio_addr_t mmio_addr,
  input  afu_mmio_pkg::mmio_tid_t  mmio_tid,
  input  afu_mmio_pkg::mmio_data_t mmio_wdata,
  input  afu_mmio_pkg::state_e     state,
  output logic                     mmio_rsp_valid,
  output afu_mmio_pkg::mmio_tid_t  mmio_rsp_tid,
  output afu_mmio_pkg::mmio_data_t mmio_rsp_data,
  output afu_mmio_pkg::cmd_e       cmd,
  output afu_mem_pkg::host_addr_t  io_addr,
  output afu_mem_pkg::mem_addr_t   mem_addr,
  output afu_mem_pkg::mem_addr_t   data_size
);
  import afu_mmio_pkg::*;
  import afu_mem_pkg::*;

  // Command pulse in the cycle of the write
  assign cmd = (mmio_wr_valid && (mmio_addr == MMIO_CMD_TYPE)) ?
               cmd_e'(mmio_wdata[2:0]) : CMD_NONE;

  always_ff @(posedge clk) begin
    if (mmio_wr_valid) begin
      case (mmio_addr)
        MMIO_IO_ADDR:   io_addr   <= host_addr_t'(mmio_wdata);
        MMIO_MEM_ADDR:  mem_addr  <= mem_addr_t'(mmio_wdata);
        MMIO_DATA_SIZE: data_size <= mem_addr_t'(mmio_wdata);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mmio_rsp_valid <= 1'b0;
    end else begin
      mmio_rsp_valid <= mmio_rd_valid;
    end
  end

  always_ff @(posedge clk) begin
    mmio_rsp_tid <= mmio_tid;   // Echoed with the response
    if (mmio_rd_valid) begin
      case (mmio_addr)
        MMIO_DFH:    mmio_rsp_data <= AFU_DFH;
        MMIO_ID_L:   mmio_rsp_data <= AFU_ID[63:0];
        MMIO_ID_H:   mmio_rsp_data <= AFU_ID[127:64];
        MMIO_STATUS: mmio_rsp_data <= mmio_data_t'(state);
        default:     mmio_rsp_data <= '0;
      endcase
    end
  end

endmodule

// File: hw/cmd_fsm.sv
module cmd_fsm (
  input  logic                 clk,
  input  logic                 reset,
  input  afu_mmio_pkg::cmd_e   cmd,
  input  logic                 read_done,
  input  logic                 write_done,
  output afu_mmio_pkg::state_e state,
  output logic                 start_read,
  output logic                 start_write
);
  import afu_mmio_pkg::*;

  // Commands only taken while idle
  assign start_read  = (state == STATE_IDLE) && (cmd == CMD_MEM_READ);
  assign start_write = (state == STATE_IDLE) && (cmd == CMD_MEM_WRITE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= STATE_IDLE;
    end else begin
      case (state)
        STATE_IDLE: begin
          if (start_read) begin
            state <= STATE_READ;
          end else if (start_write) begin
            state <= STATE_WRITE;
          end
        end
        STATE_READ: begin
          if (read_done) state <= STATE_IDLE;
        end
        STATE_WRITE: begin
          if (write_done) state <= STATE_IDLE;
        end
        default: state <= STATE_IDLE;
      endcase
    end
  end

endmodule

// File: hw/host_to_mem_copy.sv
module host_to_mem_copy (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start_write,
  input  afu_mem_pkg::host_addr_t io_addr,
  input  afu_mem_pkg::mem_addr_t  mem_addr,
  input  afu_mem_pkg::mem_addr_t  data_size,
  input  logic                    host_rd_rsp_valid,
  input  afu_mem_pkg::rd_tag_t    host_rd_rsp_tag,
  input  afu_mem_pkg::line_t      host_rd_rsp_data,
  input  logic                    host_rd_almost_full,
  input  logic                    mem_wr_ready,
  output logic                    host_rd_req_valid,
  output afu_mem_pkg::host_addr_t host_rd_req_addr,
  output afu_mem_pkg::rd_tag_t    host_rd_req_tag,
  output logic                    mem_wr_valid,
  output afu_mem_pkg::mem_addr_t  mem_wr_addr,
  output afu_mem_pkg::line_t      mem_wr_data,
  output logic                    write_done
);
  import afu_mem_pkg::*;

  localparam int PEND_W = $clog2(RD_QUEUE_DEPTH + 1);
  localparam int Q_W    = $bits(line_t) + $bits(rd_tag_t);

  logic              busy;
  logic              req_en;
  logic              req_wait;      // Batch issued, waiting for its responses
  mem_addr_t         req_ctr;
  mem_addr_t         req_ctr_next;
  rd_tag_t           rsp_ctr;
  logic [PEND_W-1:0] pending;
  logic [PEND_W-1:0] pending_next;
  mem_addr_t         wr_ctr;
  mem_addr_t         wr_base;
  logic              rsp_fire;
  logic              q_pop;
  logic              q_empty;
  logic [Q_W-1:0]    q_dout;
  rd_tag_t           q_tag;

  assign host_rd_req_valid = req_en && !req_wait;
  assign host_rd_req_tag   = rd_tag_t'(req_ctr);
  assign req_ctr_next      = req_ctr + mem_addr_t'(host_rd_req_valid);
  assign rsp_fire          = busy && host_rd_rsp_valid;

  assign mem_wr_valid        = !q_empty;
  assign q_pop               = mem_wr_valid && mem_wr_ready;
  assign {mem_wr_data, q_tag} = q_dout;
  assign mem_wr_addr         = wr_base + mem_addr_t'(q_tag);
  assign write_done          = (wr_ctr == data_size);

  // Requests in flight plus lines still queued
  always_comb begin
    pending_next = pending;
    if (host_rd_req_valid && !q_pop) begin
      pending_next = pending + 1'b1;
    end else if (!host_rd_req_valid && q_pop) begin
      pending_next = pending - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      req_en   <= 1'b0;
      req_wait <= 1'b0;
      req_ctr  <= '0;
      rsp_ctr  <= '0;
      pending  <= '0;
      wr_ctr   <= '0;
    end else if (start_write) begin
      busy     <= 1'b1;
      req_en   <= 1'b0;
      req_wait <= 1'b0;
      req_ctr  <= '0;
      rsp_ctr  <= '0;
      pending  <= '0;
      wr_ctr   <= '0;
    end else begin
      if (write_done) busy <= 1'b0;
      req_en <= busy && (req_ctr_next != data_size)
             && (pending_next != PEND_W'(RD_QUEUE_DEPTH)) && !host_rd_almost_full;
      if (host_rd_req_valid) begin
        req_ctr <= req_ctr_next;
        if (host_rd_req_tag == rd_tag_t'(RD_WINDOW - 1)) req_wait <= 1'b1;
      end
      if (rsp_fire) begin
        rsp_ctr <= rsp_ctr + 1'b1;
        if (rsp_ctr == rd_tag_t'(RD_WINDOW - 1)) req_wait <= 1'b0;   // Batch complete
      end
      if (q_pop) wr_ctr <= wr_ctr + 1'b1;
      pending <= pending_next;
    end
  end

  always_ff @(posedge clk) begin
    if (start_write) begin
      host_rd_req_addr <= io_addr;
      wr_base          <= mem_addr;
    end else begin
      if (host_rd_req_valid) host_rd_req_addr <= host_rd_req_addr + 1'b1;
      // Next batch base after the last line of a window
      if (q_pop && (rd_tag_t'(wr_ctr) == rd_tag_t'(RD_WINDOW - 1))) begin
        wr_base <= wr_base + mem_addr_t'(RD_WINDOW);
      end
    end
  end

  line_fifo #(
    .DATAW (Q_W),
    .DEPTH (RD_QUEUE_DEPTH)
  ) u_rd_queue (
    .clk      (clk),
    .reset    (reset),
    .push     (rsp_fire),
    .data_in  ({host_rd_rsp_data, host_rd_rsp_tag}),
    .pop      (q_pop),
    .data_out (q_dout),
    .empty    (q_empty),
    .full     ()
  );

endmodule

// File: hw/mem_to_host_copy.sv
module mem_to_host_copy (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start_read,
  input  afu_mem_pkg::host_addr_t io_addr,
  input  afu_mem_pkg::mem_addr_t  mem_addr,
  input  afu_mem_pkg::mem_addr_t  data_size,
  input  logic                    mem_rd_ready,
  input  logic                    rd_line_valid,
  input  afu_mem_pkg::line_t      rd_line_data,
  input  logic                    host_wr_almost_full,
  input  logic                    host_wr_rsp_valid,
  output logic                    mem_rd_valid,
  output afu_mem_pkg::mem_addr_t  mem_rd_addr,
  output logic                    rd_line_pop,
  output logic                    host_wr_req_valid,
  output afu_mem_pkg::host_addr_t host_wr_req_addr,
  output afu_mem_pkg::line_t      host_wr_req_data,
  output logic                    read_done
);
  import afu_mem_pkg::*;

  mem_addr_t rd_ctr;    // Local reads left to issue
  mem_addr_t wr_ctr;    // Host writes left to issue
  mem_addr_t ack_ctr;   // Writes waiting for acknowledgment
  logic      rd_fire;

  assign mem_rd_valid      = (rd_ctr != '0);
  assign rd_fire           = mem_rd_valid && mem_rd_ready;
  assign host_wr_req_valid = rd_line_valid && !host_wr_almost_full;
  assign rd_line_pop       = host_wr_req_valid;
  assign host_wr_req_data  = rd_line_data;
  assign read_done         = (wr_ctr == '0) && (ack_ctr == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ctr  <= '0;
      wr_ctr  <= '0;
      ack_ctr <= '0;
    end else if (start_read) begin
      rd_ctr  <= data_size;
      wr_ctr  <= data_size;
      ack_ctr <= '0;
    end else begin
      if (rd_fire) rd_ctr <= rd_ctr - 1'b1;
      if (host_wr_req_valid) wr_ctr <= wr_ctr - 1'b1;
      case ({host_wr_req_valid, host_wr_rsp_valid})
        2'b10:   ack_ctr <= ack_ctr + 1'b1;
        2'b01:   ack_ctr <= ack_ctr - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_read) begin
      mem_rd_addr      <= mem_addr;
      host_wr_req_addr <= io_addr;
    end else begin
      if (rd_fire) mem_rd_addr <= mem_rd_addr + 1'b1;
      if (host_wr_req_valid) host_wr_req_addr <= host_wr_req_addr + 1'b1;
    end
  end

endmodule

// File: hw/local_mem_master.sv
module local_mem_master (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   mem_wr_valid,
  input  afu_mem_pkg::mem_addr_t mem_wr_addr,
  input  afu_mem_pkg::line_t     mem_wr_data,
  input  logic                   mem_rd_valid,
  input  afu_mem_pkg::mem_addr_t mem_rd_addr,
  input  logic                   rd_line_pop,
  input  logic                   avs_waitrequest,
  input  afu_mem_pkg::line_t     avs_readdata,
  input  logic                   avs_readdatavalid,
  output logic                   mem_wr_ready,
  output logic                   mem_rd_ready,
  output logic                   rd_line_valid,
  output afu_mem_pkg::line_t     rd_line_data,
  output afu_mem_pkg::mem_addr_t avs_address,
  output afu_mem_pkg::line_t     avs_writedata,
  output logic                   avs_read,
  output logic                   avs_write
);
  import afu_mem_pkg::*;

  localparam int CNT_W = $clog2(AVS_RD_DEPTH + 1);

  logic [CNT_W-1:0] rd_count;   // Reads in flight plus queued lines
  logic             rd_space;
  logic             rd_fire;
  logic             q_pop;
  logic             q_empty;

  assign rd_space      = (rd_count != CNT_W'(AVS_RD_DEPTH));
  assign avs_write     = mem_wr_valid;
  assign avs_read      = mem_rd_valid && !mem_wr_valid && rd_space;   // Writes first
  assign avs_address   = mem_wr_valid ? mem_wr_addr : mem_rd_addr;
  assign avs_writedata = mem_wr_data;
  assign mem_wr_ready  = !avs_waitrequest;
  assign mem_rd_ready  = !avs_waitrequest && !mem_wr_valid && rd_space;
  assign rd_fire       = avs_read && !avs_waitrequest;
  assign rd_line_valid = !q_empty;
  assign q_pop         = rd_line_pop && !q_empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_count <= '0;
    end else begin
      rd_count <= rd_count + CNT_W'(rd_fire) - CNT_W'(q_pop);
    end
  end

  line_fifo #(
    .DATAW ($bits(line_t)),
    .DEPTH (AVS_RD_DEPTH)
  ) u_rd_data_queue (
    .clk      (clk),
    .reset    (reset),
    .push     (avs_readdatavalid),
    .data_in  (avs_readdata),
    .pop      (q_pop),
    .data_out (rd_line_data),
    .empty    (q_empty),
    .full     ()
  );

endmodule

// File: hw/line_fifo.sv
module line_fifo #(
  parameter int DATAW = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             push,
  input  logic [DATAW-1:0] data_in,
  input  logic             pop,
  output logic [DATAW-1:0] data_out,
  output logic             empty,
  output logic             full
);
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [DATAW-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             do_push;
  logic             do_pop;

  // Wraps at DEPTH, so any depth works
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign empty    = (count == '0);
  assign full     = (count == CW'(DEPTH));
  assign data_out = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
      count <= count + CW'(do_push) - CW'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= data_in;
  end

endmodule

// File: hw/afu_mem_pkg.sv
package afu_mem_pkg;

  typedef logic [511:0] line_t;
  typedef logic [41:0]  host_addr_t;   // Host cache-line address
  typedef logic [25:0]  mem_addr_t;    // Local memory line address
  typedef logic [2:0]   rd_tag_t;

  // Host reads per batch, one tag each
  localparam int RD_WINDOW = 8;

  localparam int RD_QUEUE_DEPTH = 16;

  // Local reads in flight plus lines waiting in the read queue
  localparam int AVS_RD_DEPTH = 16;

endpackage

// File: hw/afu_mmio_pkg.sv
package afu_mmio_pkg;

  typedef logic [15:0] mmio_addr_t;
  typedef logic [63:0] mmio_data_t;
  typedef logic [8:0]  mmio_tid_t;

  typedef enum logic [2:0] {
    CMD_NONE      = 3'd0,
    CMD_MEM_READ  = 3'd1,
    CMD_MEM_WRITE = 3'd2
  } cmd_e;

  typedef enum logic [1:0] {
    STATE_IDLE  = 2'd0,
    STATE_READ  = 2'd1,
    STATE_WRITE = 2'd2
  } state_e;

  localparam mmio_addr_t MMIO_DFH       = 16'h0000;
  localparam mmio_addr_t MMIO_ID_L      = 16'h0002;
  localparam mmio_addr_t MMIO_ID_H      = 16'h0004;
  localparam mmio_addr_t MMIO_NEXT_AFU  = 16'h0006;
  localparam mmio_addr_t MMIO_RSVD      = 16'h0008;
  localparam mmio_addr_t MMIO_IO_ADDR   = 16'h000A;
  localparam mmio_addr_t MMIO_MEM_ADDR  = 16'h000C;
  localparam mmio_addr_t MMIO_DATA_SIZE = 16'h000E;
  localparam mmio_addr_t MMIO_CMD_TYPE  = 16'h0010;
  localparam mmio_addr_t MMIO_STATUS    = 16'h0012;

  // Feature type AFU, last entry of the DFH list
  localparam mmio_data_t   AFU_DFH = 64'h1000_0100_0000_0000;
  localparam logic [127:0] AFU_ID  = 128'h5e1c_0a47_93b2_4d6f_a0c3_71e8_2b9d_f416;

endpackage
